// ==== executeStage.f ====
+incdir+.
rvArchPkg.sv
execOpPkg.sv
intAluPath.sv
branchResolver.sv
execRetire.sv
executeStage.sv
tbExecuteStage.sv

// ==== Makefile ====
SRCS = rvArchPkg.sv execOpPkg.sv intAluPath.sv branchResolver.sv execRetire.sv \
       executeStage.sv tbExecuteStage.sv tbExecuteModel.svh

obj_dir/VtbExecuteStage: executeStage.f $(SRCS)
	verilator --binary --timing --assert --top-module tbExecuteStage -f executeStage.f

run: obj_dir/VtbExecuteStage
	./obj_dir/VtbExecuteStage

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== tbExecuteModel.svh ====
//##########################################################################
// reference model of the integer execute stage
// ALU, branch condition and trap rules, expected registered output
//##########################################################################

`ifndef TB_EXECUTE_MODEL_SVH
`define TB_EXECUTE_MODEL_SVH

// flipping both sign bits turns a signed compare into an unsigned one
function automatic logic signedLess(word_t a, word_t b);
    return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
endfunction

function automatic word_t aluModel(ExecIn i);
    word_t a;
    word_t b;
    logic [63:0] wide;
    int unsigned sh;
    a = (i.op.aluSrc1 == AluSrc1_Pc) ? i.pc : (i.op.aluSrc1 == AluSrc1_Reg) ? i.src1 : '0;
    b = (i.op.aluSrc2 == AluSrc2_Imm) ? i.op.imm
        : (i.op.aluSrc2 == AluSrc2_Reg) ? i.src2 : '0;
    sh = b % 32;
    wide = {{32{a[31]}}, a} >> sh;
    case (i.op.aluCommand)
        AluCommand_Add: return a + b;
        AluCommand_Sub: return a + ~b + 32'd1;
        AluCommand_Sll: return a << sh;
        AluCommand_Slt: return word_t'(signedLess(a, b));
        AluCommand_Sltu: return word_t'(a < b);
        AluCommand_Xor: return a ^ b;
        AluCommand_Srl: return a >> sh;
        AluCommand_Sra: return wide[31:0];
        AluCommand_Or: return a | b;
        AluCommand_And: return a & b;
        AluCommand_Clear1: return a & ~b;
        AluCommand_Clear2: return ~a & b;
        default: return '0;
    endcase
endfunction

function automatic logic condMet(ExecIn i);
    case (i.op.branchCond)
        BranchCond_Eq: return i.src1 == i.src2;
        BranchCond_Ne: return i.src1 != i.src2;
        BranchCond_Lt: return signedLess(i.src1, i.src2);
        BranchCond_Ge: return !signedLess(i.src1, i.src2);
        BranchCond_Ltu: return i.src1 < i.src2;
        BranchCond_Geu: return !(i.src1 < i.src2);
        BranchCond_Always: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic TrapInfo trapModel(ExecIn i, Privilege p, logic s, logic w);
    TrapInfo t;
    t = '0;
    case (i.op.trapOp)
        TrapOp_Ecall: begin
            t.valid = 1'b1;
            t.code = (p == Privilege_User) ? EXC_ECALL_FROM_U
                : (p == Privilege_Supervisor) ? EXC_ECALL_FROM_S : EXC_ECALL_FROM_M;
        end
        TrapOp_Ebreak: begin
            t.valid = 1'b1;
            t.code = EXC_BREAKPOINT;
        end
        TrapOp_Sret: begin
            if (p == Privilege_Supervisor && s) begin
                t = '{valid: 1'b1, code: EXC_ILLEGAL_INSN, value: i.insn};
            end
        end
        TrapOp_Wfi: begin
            if (p != Privilege_Machine && w) begin
                t = '{valid: 1'b1, code: EXC_ILLEGAL_INSN, value: i.insn};
            end
        end
        default: t = '0;
    endcase
    return t;
endfunction

// expected register contents one edge after sampling these inputs
function automatic ExecOut expectedOut(logic r, ExecIn i, Privilege p, logic s, logic w);
    ExecOut e;
    addr_t nextPc;
    addr_t target;
    logic taken;
    e = '0;
    if (!r && i.valid) begin
        nextPc = i.pc + ((COMPRESSED_EN && i.isCompressed) ? 32'd2 : 32'd4);
        target = i.op.indirect ? ((i.src1 + i.op.imm) & ~32'h1) : i.pc + i.op.imm;
        taken = condMet(i);
        e.valid = 1'b1;
        e.pc = i.pc;
        e.rd = i.op.rd;
        e.trap = trapModel(i, p, s, w);
        e.trapReturn = (i.op.trapOp == TrapOp_Sret || i.op.trapOp == TrapOp_Mret)
            && !e.trap.valid;
        e.intRegWriteEnable = i.op.intRegWriteEnable && !e.trap.valid;
        e.dstValue = (i.op.dstSrc == DstSrc_NextPc) ? nextPc : aluModel(i);
        e.branchTaken = taken;
        e.branchTarget = target;
        e.flushReq = taken || e.trap.valid || e.trapReturn;
        e.flushTarget = taken ? target : nextPc;
    end
    return e;
endfunction

`endif

// ==== tbExecuteStage.sv ====
//##########################################################################
// testbench of the integer execute stage
// random and directed operations checked against the reference model
// one edge after they are sampled, plus a run-length watchdog
//##########################################################################

`timescale 1ns/1ps

module tbExecuteStage
    import rvArchPkg::*;
    import execOpPkg::*;
();

    localparam bit COMPRESSED_EN = 1'b1;
    localparam int CLK_PERIOD = 40;
    localparam int ALU_OPS = 200;
    localparam int BRANCH_OPS = 150;
    localparam int JUMP_OPS = 40;
    // reset, traps, xret/wfi, bubbles, ops under reset and the drain cycles
    localparam int TOTAL_OPS = 3 + ALU_OPS + BRANCH_OPS + JUMP_OPS + 6 + 36 + 20 + 3 + 4;

    logic clk;
    logic rst;
    ExecIn in;
    Privilege priv;
    logic tsr;
    logic tw;
    ExecOut out;

    int seed = 49218;
    string testName = "reset";
    string prevName;
    ExecOut prevExp;
    logic havePrev = 1'b0;
    int checkCount = 0;

    `include "tbExecuteModel.svh"

    executeStage #(
        .COMPRESSED_EN(COMPRESSED_EN)
    ) dut (
        .clk(clk),
        .rst(rst),
        .in(in),
        .priv(priv),
        .tsr(tsr),
        .tw(tw),
        .out(out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t randWord();
        return $random(seed);
    endfunction

    function automatic int unsigned pick(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "execute stage testbench stopped");
    endtask

    task automatic checkWord(input string name, input string field, input word_t expected,
            input word_t actual);
        if (expected !== actual) begin
            abortRun($sformatf("error %s: %s expected %h actual %h", name, field,
                expected, actual));
        end
    endtask

    task automatic compareFlag(input string name, input string field, input logic expected,
            input logic actual);
        if (expected !== actual) begin
            abortRun($sformatf("error %s: %s expected %b actual %b", name, field,
                expected, actual));
        end
    endtask

    task automatic checkBranch(input string name, input logic expTaken, input addr_t expTarget,
            input logic actTaken, input addr_t actTarget);
        if ({expTaken, expTarget} !== {actTaken, actTarget}) begin
            abortRun($sformatf("error %s: branch expected taken %b target %h actual %b %h",
                name, expTaken, expTarget, actTaken, actTarget));
        end
    endtask

    task automatic checkTrap(input string name, input TrapInfo expected, input TrapInfo actual);
        if (expected !== actual) begin
            abortRun($sformatf("error %s: trap expected %b/%0d/%h actual %b/%0d/%h", name,
                expected.valid, expected.code, expected.value,
                actual.valid, actual.code, actual.value));
        end
    endtask

    task automatic checkFlush(input string name, input logic expReq, input addr_t expTarget,
            input logic actReq, input addr_t actTarget);
        if ({expReq, expTarget} !== {actReq, actTarget}) begin
            abortRun($sformatf("error %s: flush expected req %b target %h actual %b %h",
                name, expReq, expTarget, actReq, actTarget));
        end
    endtask

    task automatic driveOp(input string name, input ExecIn x, input Privilege p,
            input logic s, input logic w);
        @(posedge clk);
        testName <= name;
        in <= x;
        priv <= p;
        tsr <= s;
        tw <= w;
    endtask

    // even pc and imm keep every direct target aligned
    function automatic ExecIn randomOp();
        ExecIn x;
        x = '0;
        x.valid = 1'b1;
        x.pc = randWord() & ~32'h1;
        x.insn = randWord();
        x.isCompressed = pick(2) == 1;
        x.src1 = randWord();
        x.src2 = (pick(4) == 0) ? x.src1 : randWord();
        x.op.aluCommand = AluCommand'(pick(12));
        x.op.aluSrc1 = AluSrc1'(pick(3));
        x.op.aluSrc2 = AluSrc2'(pick(3));
        x.op.rd = regIdx_t'(pick(32));
        x.op.intRegWriteEnable = pick(2) == 1;
        x.op.imm = randWord() & ~32'h1;
        return x;
    endfunction

    // out seen at an edge was registered at the edge before
    always @(posedge clk) begin
        if (havePrev) begin
            compareFlag(prevName, "valid", prevExp.valid, out.valid);
            checkWord(prevName, "pc", prevExp.pc, out.pc);
            checkWord(prevName, "rd", word_t'(prevExp.rd), word_t'(out.rd));
            compareFlag(prevName, "rd write", prevExp.intRegWriteEnable, out.intRegWriteEnable);
            checkWord(prevName, "dstValue", prevExp.dstValue, out.dstValue);
            checkBranch(prevName, prevExp.branchTaken, prevExp.branchTarget,
                out.branchTaken, out.branchTarget);
            checkTrap(prevName, prevExp.trap, out.trap);
            compareFlag(prevName, "trapReturn", prevExp.trapReturn, out.trapReturn);
            checkFlush(prevName, prevExp.flushReq, prevExp.flushTarget,
                out.flushReq, out.flushTarget);
            checkCount <= checkCount + 1;
        end
        prevExp = expectedOut(rst, in, priv, tsr, tw);
        prevName = testName;
        havePrev = 1'b1;
    end

    initial begin
        #(CLK_PERIOD * (TOTAL_OPS + 50));
        abortRun("watchdog expired before the tests finished");
    end

    initial begin
        ExecIn x;
        Privilege privs[3];
        TrapOp xrets[3];
        int f;
        privs = '{Privilege_User, Privilege_Supervisor, Privilege_Machine};
        xrets = '{TrapOp_Sret, TrapOp_Mret, TrapOp_Wfi};
        rst = 1'b1;
        in = '0;
        priv = Privilege_Machine;
        tsr = 1'b0;
        tw = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        repeat (ALU_OPS) begin
            driveOp("alu", randomOp(), Privilege_Machine, 1'b0, 1'b0);
        end
        repeat (BRANCH_OPS) begin
            x = randomOp();
            x.op.branchCond = BranchCond'(pick(8));
            x.op.indirect = pick(2) == 1;
            driveOp("branch", x, Privilege_Machine, 1'b0, 1'b0);
        end
        repeat (JUMP_OPS) begin
            x = randomOp();
            x.op.branchCond = BranchCond_Always;
            x.op.indirect = pick(2) == 1;
            x.op.dstSrc = DstSrc_NextPc;
            driveOp("jump link", x, Privilege_Machine, 1'b0, 1'b0);
        end
        foreach (privs[p]) begin
            x = randomOp();
            x.op.intRegWriteEnable = 1'b1;
            x.op.trapOp = TrapOp_Ecall;
            driveOp("ecall", x, privs[p], 1'b0, 1'b0);
            x.op.trapOp = TrapOp_Ebreak;
            driveOp("ebreak", x, privs[p], 1'b1, 1'b1);
        end
        // every tsr/tw pair at every privilege level
        foreach (privs[p]) begin
            for (f = 0; f < 4; f++) begin
                foreach (xrets[k]) begin
                    x = randomOp();
                    x.op.trapOp = xrets[k];
                    driveOp("xret and wfi", x, privs[p], f[0], f[1]);
                end
            end
        end
        repeat (20) begin
            x = randomOp();
            x.valid = 1'b0;
            x.op.trapOp = TrapOp_Ecall;
            driveOp("bubble", x, Privilege_User, 1'b1, 1'b1);
        end
        rst <= 1'b1;
        repeat (3) begin
            driveOp("valid under reset", randomOp(), Privilege_Machine, 1'b0, 1'b0);
        end
        @(posedge clk);
        in <= '0;
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (checkCount < ALU_OPS + BRANCH_OPS + JUMP_OPS) begin
            abortRun("too few output cycles were compared");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== executeStage.sv ====
//##########################################################################
// integer execute stage top level
// ALU path and branch resolver side by side, feeding the retire
// logic that registers the stage output
//##########################################################################

`timescale 1ns/1ps

module executeStage
    import rvArchPkg::*;
    import execOpPkg::*;
#(
    parameter bit COMPRESSED_EN = 1'b1
) (
    input logic clk,
    input logic rst,
    input ExecIn in,
    input Privilege priv,
    input logic tsr,
    input logic tw,
    output ExecOut out
);

    word_t aluResult;
    BranchResult branch;

    intAluPath aluPath (
        .in(in),
        .aluResult(aluResult)
    );

    branchResolver #(
        .COMPRESSED_EN(COMPRESSED_EN)
    ) resolver (
        .in(in),
        .branch(branch)
    );

    execRetire retire (
        .clk(clk),
        .rst(rst),
        .in(in),
        .aluResult(aluResult),
        .branch(branch),
        .priv(priv),
        .tsr(tsr),
        .tw(tw),
        .out(out)
    );

endmodule

// ==== execRetire.sv ====
//##########################################################################
// retire logic of the execute stage
// trap detection by priority, destination value, flush request
// and the output register towards the next stage
//##########################################################################

`timescale 1ns/1ps

module execRetire
    import rvArchPkg::*;
    import execOpPkg::*;
(
    input logic clk,
    input logic rst,
    input ExecIn in,
    input word_t aluResult,
    input BranchResult branch,
    input Privilege priv,
    input logic tsr,
    input logic tw,
    output ExecOut out
);

    TrapInfo trap;
    logic trapReturn;
    logic taken;
    ExecOut nextOut;

    assign taken = in.valid && branch.taken;

    // ecall first, then ebreak, sret under tsr and wfi under tw
    always_comb begin
        trap = '0;
        if (in.valid) begin
            if (in.op.trapOp == TrapOp_Ecall) begin
                trap.valid = 1'b1;
                case (priv)
                    Privilege_User: trap.code = EXC_ECALL_FROM_U;
                    Privilege_Supervisor: trap.code = EXC_ECALL_FROM_S;
                    default: trap.code = EXC_ECALL_FROM_M;
                endcase
            end else if (in.op.trapOp == TrapOp_Ebreak) begin
                trap.valid = 1'b1;
                trap.code = EXC_BREAKPOINT;
            end else if (in.op.trapOp == TrapOp_Sret && priv == Privilege_Supervisor
                    && tsr) begin
                trap.valid = 1'b1;
                trap.code = EXC_ILLEGAL_INSN;
                trap.value = in.insn;
            end else if (in.op.trapOp == TrapOp_Wfi && priv != Privilege_Machine
                    && tw) begin
                trap.valid = 1'b1;
                trap.code = EXC_ILLEGAL_INSN;
                trap.value = in.insn;
            end
        end
    end

    // sret returns only when tsr lets supervisor code run it
    assign trapReturn = in.valid && ((in.op.trapOp == TrapOp_Mret)
        || (in.op.trapOp == TrapOp_Sret && !(priv == Privilege_Supervisor && tsr)));

    always_comb begin
        nextOut.valid = in.valid;
        nextOut.pc = in.pc;
        nextOut.rd = in.op.rd;
        // a trapping insn must not write rd
        nextOut.intRegWriteEnable = in.op.intRegWriteEnable && !trap.valid;
        if (in.op.dstSrc == DstSrc_NextPc) begin
            nextOut.dstValue = branch.nextPc;
        end else begin
            nextOut.dstValue = aluResult;
        end
        nextOut.branchTaken = taken;
        nextOut.branchTarget = branch.target;
        nextOut.trap = trap;
        nextOut.trapReturn = trapReturn;
        nextOut.flushReq = taken || trap.valid || trapReturn;
        nextOut.flushTarget = taken ? branch.target : branch.nextPc;
    end

    // bubble cycles leave the register all zero
    always_ff @(posedge clk) begin
        if (rst || !in.valid) begin
            out <= '0;
        end else begin
            out <= nextOut;
        end
    end

    // a trapped xret hands no return to the next stage
    trapOrReturn: assert property (@(posedge clk) disable iff (rst)
        !(out.trap.valid && out.trapReturn))
        else $error("trap and trap return both set at pc %h", out.pc);

endmodule

// ==== branchResolver.sv ====
//##########################################################################
// branch resolution of the execute stage
// condition evaluation, direct and indirect target, next pc
//##########################################################################

`timescale 1ns/1ps

module branchResolver
    import rvArchPkg::*;
    import execOpPkg::*;
#(
    parameter bit COMPRESSED_EN = 1'b1
) (
    input ExecIn in,
    output BranchResult branch
);

    addr_t jumpSum;
    addr_t pcStep;

    always_comb begin
        // 16-bit insns only advance by 2 when RVC is built in
        pcStep = (COMPRESSED_EN && in.isCompressed) ? addr_t'(2) : addr_t'(4);
        jumpSum = in.src1 + in.op.imm;

        branch.nextPc = in.pc + pcStep;
        if (in.op.indirect) begin
            // jalr drops bit 0 of the sum
            branch.target = {jumpSum[$bits(addr_t)-1:1], 1'b0};
        end else begin
            branch.target = in.pc + in.op.imm;
        end

        case (in.op.branchCond)
            BranchCond_Eq: branch.taken = (in.src1 == in.src2);
            BranchCond_Ne: branch.taken = (in.src1 != in.src2);
            BranchCond_Lt: branch.taken = ($signed(in.src1) < $signed(in.src2));
            BranchCond_Ge: branch.taken = ($signed(in.src1) >= $signed(in.src2));
            BranchCond_Ltu: branch.taken = (in.src1 < in.src2);
            BranchCond_Geu: branch.taken = (in.src1 >= in.src2);
            BranchCond_Always: branch.taken = 1'b1;
            default: branch.taken = 1'b0;
        endcase
    end

    // fetch cannot redirect to an odd address
    always_comb begin
        if (in.valid && branch.taken) begin
            targetAligned: assert final (!branch.target[0])
                else $error("taken branch to odd target %h", branch.target);
        end
    end

endmodule

// ==== intAluPath.sv ====
//##########################################################################
// integer ALU path of the execute stage
// operand selection from zero, pc, immediate or register
// add/sub, shifts, compares and bitwise operations
//##########################################################################

`timescale 1ns/1ps

module intAluPath
    import rvArchPkg::*;
    import execOpPkg::*;
(
    input ExecIn in,
    output word_t aluResult
);

    word_t op1;
    word_t op2;
    logic [SHAMT_WIDTH-1:0] shamt;

    // operand muxes
    always_comb begin
        case (in.op.aluSrc1)
            AluSrc1_Zero: op1 = '0;
            AluSrc1_Pc: op1 = in.pc;
            AluSrc1_Reg: op1 = in.src1;
            default: op1 = '0;
        endcase

        case (in.op.aluSrc2)
            AluSrc2_Zero: op2 = '0;
            AluSrc2_Imm: op2 = in.op.imm;
            AluSrc2_Reg: op2 = in.src2;
            default: op2 = '0;
        endcase
    end

    // only the low bits count for shifts
    assign shamt = op2[SHAMT_WIDTH-1:0];

    always_comb begin
        case (in.op.aluCommand)
            AluCommand_Add: aluResult = op1 + op2;
            AluCommand_Sub: aluResult = op1 - op2;
            AluCommand_Sll: aluResult = op1 << shamt;
            AluCommand_Slt: aluResult = word_t'($signed(op1) < $signed(op2));
            AluCommand_Sltu: aluResult = word_t'(op1 < op2);
            AluCommand_Xor: aluResult = op1 ^ op2;
            AluCommand_Srl: aluResult = op1 >> shamt;
            AluCommand_Sra: aluResult = word_t'($signed(op1) >>> shamt);
            AluCommand_Or: aluResult = op1 | op2;
            AluCommand_And: aluResult = op1 & op2;
            // bit clear as used by csrrc style operations
            AluCommand_Clear1: aluResult = op1 & ~op2;
            AluCommand_Clear2: aluResult = ~op1 & op2;
            default: aluResult = '0;
        endcase
    end

    // decoder must never hand over a reserved encoding
    always_comb begin
        if (in.valid) begin
            aluCmdDefined: assert final (in.op.aluCommand <= AluCommand_Clear2)
                else $error("undefined ALU command %0d", in.op.aluCommand);
        end
    end

endmodule

// ==== execOpPkg.sv ====
//##########################################################################
// decoded operation format of the integer execute stage
// ALU command, operand source, branch and trap enums
// stage input, branch result and stage output structs
//##########################################################################

package execOpPkg;

    import rvArchPkg::*;

    // encodings are dense from zero
    typedef enum logic [3:0] {
        AluCommand_Add,
        AluCommand_Sub,
        AluCommand_Sll,
        AluCommand_Slt,
        AluCommand_Sltu,
        AluCommand_Xor,
        AluCommand_Srl,
        AluCommand_Sra,
        AluCommand_Or,
        AluCommand_And,
        AluCommand_Clear1,
        AluCommand_Clear2
    } AluCommand;

    typedef enum logic [1:0] {
        AluSrc1_Zero,
        AluSrc1_Pc,
        AluSrc1_Reg
    } AluSrc1;

    typedef enum logic [1:0] {
        AluSrc2_Zero,
        AluSrc2_Imm,
        AluSrc2_Reg
    } AluSrc2;

    typedef enum logic [2:0] {
        BranchCond_None,
        BranchCond_Eq,
        BranchCond_Ne,
        BranchCond_Lt,
        BranchCond_Ge,
        BranchCond_Ltu,
        BranchCond_Geu,
        BranchCond_Always
    } BranchCond;

    typedef enum logic {
        DstSrc_Result,
        DstSrc_NextPc
    } DstSrc;

    typedef enum logic [2:0] {
        TrapOp_None,
        TrapOp_Ecall,
        TrapOp_Ebreak,
        TrapOp_Sret,
        TrapOp_Mret,
        TrapOp_Wfi
    } TrapOp;

    typedef struct packed {
        AluCommand aluCommand;
        AluSrc1 aluSrc1;
        AluSrc2 aluSrc2;
        BranchCond branchCond;
        logic indirect;
        DstSrc dstSrc;
        TrapOp trapOp;
        regIdx_t rd;
        logic intRegWriteEnable;
        word_t imm;
    } ExecOp;

    typedef struct packed {
        logic valid;
        addr_t pc;
        insn_t insn;
        logic isCompressed;
        word_t src1;
        word_t src2;
        ExecOp op;
    } ExecIn;

    typedef struct packed {
        logic taken;
        addr_t target;
        addr_t nextPc;
    } BranchResult;

    typedef struct packed {
        logic valid;
        addr_t pc;
        regIdx_t rd;
        logic intRegWriteEnable;
        word_t dstValue;
        logic branchTaken;
        addr_t branchTarget;
        TrapInfo trap;
        logic trapReturn;
        logic flushReq;
        addr_t flushTarget;
    } ExecOut;

endpackage

// ==== rvArchPkg.sv ====
//##########################################################################
// RV32 architectural types shared by the execute stage
// word, address, register index and instruction widths
// privilege levels, exception cause codes and the trap record
//##########################################################################

package rvArchPkg;

    localparam int XLEN = 32;
    localparam int INSN_WIDTH = 32;
    localparam int REG_IDX_WIDTH = 5;
    localparam int EXC_CODE_WIDTH = 4;

    // shift amount of an RV32 shift
    localparam int SHAMT_WIDTH = $clog2(XLEN);

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [REG_IDX_WIDTH-1:0] regIdx_t;
    typedef logic [INSN_WIDTH-1:0] insn_t;
    typedef logic [EXC_CODE_WIDTH-1:0] excCode_t;

    // encoding 2'b10 is reserved
    typedef enum logic [1:0] {
        Privilege_User = 2'b00,
        Privilege_Supervisor = 2'b01,
        Privilege_Machine = 2'b11
    } Privilege;

    // synchronous causes raised by this stage
    localparam excCode_t EXC_ILLEGAL_INSN = 4'd2;
    localparam excCode_t EXC_BREAKPOINT = 4'd3;
    localparam excCode_t EXC_ECALL_FROM_U = 4'd8;
    localparam excCode_t EXC_ECALL_FROM_S = 4'd9;
    localparam excCode_t EXC_ECALL_FROM_M = 4'd11;

    // value is the faulting insn for illegal, zero otherwise
    typedef struct packed {
        logic valid;
        excCode_t code;
        word_t value;
    } TrapInfo;

endpackage
